// ==== files.f ====
hw/rvv_alu_pkg.sv
hw/rvv_alu_rs.sv
hw/rvv_alu_unit.sv
hw/rvv_alu.sv
hw/rvv_alu_rob.sv
hw/rvv_alu_top.sv
verif/tb_clk_gen.sv
verif/tb_rvv_alu.sv

// ==== hw/rvv_alu.sv ====
// vector ALU pair
// two ALU units on the station's two oldest entries, with in-order pop
`timescale 1ns/10ps
`default_nettype none

module rvv_alu (
  input  rvv_alu_pkg::ALU_RS_t      alu_uop0_rs2ex,
  input  rvv_alu_pkg::ALU_RS_t      alu_uop1_rs2ex,
  input  wire logic                 fifo_empty_rs2ex,
  input  wire logic                 fifo_1left_to_empty_rs2ex,
  output logic                      pop0_ex2rs,
  output logic                      pop1_ex2rs,
  output logic                      result0_valid_ex2rob,
  output rvv_alu_pkg::ALU2ROB_t     result0_ex2rob,
  input  wire logic                 result0_ready_rob2alu,
  output logic                      result1_valid_ex2rob,
  output rvv_alu_pkg::ALU2ROB_t     result1_ex2rob,
  input  wire logic                 result1_ready_rob2alu
);

  logic alu_uop0_valid_rs2ex;
  logic alu_uop1_valid_rs2ex;

  assign alu_uop0_valid_rs2ex = !fifo_empty_rs2ex;
  // second entry exists only with two or more held
  assign alu_uop1_valid_rs2ex = !fifo_empty_rs2ex && !fifo_1left_to_empty_rs2ex;

  // lane 1 never leaves ahead of lane 0
  assign pop0_ex2rs = alu_uop0_valid_rs2ex && result0_valid_ex2rob && result0_ready_rob2alu;
  assign pop1_ex2rs = pop0_ex2rs && alu_uop1_valid_rs2ex &&
                      result1_valid_ex2rob && result1_ready_rob2alu;

  rvv_alu_unit u_alu_unit0 (
    .alu_uop_valid       (alu_uop0_valid_rs2ex),
    .alu_uop             (alu_uop0_rs2ex),
    .result_valid_ex2rob (result0_valid_ex2rob),
    .result_ex2rob       (result0_ex2rob)
  );

  rvv_alu_unit u_alu_unit1 (
    .alu_uop_valid       (alu_uop1_valid_rs2ex),
    .alu_uop             (alu_uop1_rs2ex),
    .result_valid_ex2rob (result1_valid_ex2rob),
    .result_ex2rob       (result1_ex2rob)
  );

endmodule

`default_nettype wire

// ==== hw/rvv_alu_pkg.sv ====
// vector ALU package
// micro-op and result types, the element-union view of a register slice,
// and the opcode and element-width encodings
`default_nettype none

package rvv_alu_pkg;

  // reorder-buffer tag width, carried through untouched
  localparam int ROB_ENTRY_W = 4;

  typedef enum logic [2:0] {
    OP_VADD  = 3'd0,
    OP_VSUB  = 3'd1,
    OP_VAND  = 3'd2,
    OP_VOR   = 3'd3,
    OP_VXOR  = 3'd4,
    OP_VMINU = 3'd5,
    OP_VMAXU = 3'd6
  } alu_op_e;

  typedef enum logic {
    SEW8  = 1'b0,
    SEW16 = 1'b1
  } sew_e;

  // one 32-bit slice, read as four bytes or two halfwords depending on SEW
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } vreg_slice_u;

  // micro-op held in the reservation station
  typedef struct packed {
    logic [ROB_ENTRY_W-1:0] rob_entry;
    alu_op_e                opcode;
    sew_e                   sew;
    vreg_slice_u            vs1;
    vreg_slice_u            vs2;
  } ALU_RS_t;

  // result sent toward the reorder buffer
  typedef struct packed {
    logic [ROB_ENTRY_W-1:0] rob_entry;
    vreg_slice_u            vd_data;
  } ALU2ROB_t;

endpackage

`default_nettype wire

// ==== hw/rvv_alu_rob.sv ====
// ALU commit buffer
// two write ports filled in lane order, one retire per cycle from the head
`timescale 1ns/10ps
`default_nettype none

module rvv_alu_rob #(
  parameter int ROB_BUF_DEPTH = 4
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 result0_valid_ex2rob,
  input  rvv_alu_pkg::ALU2ROB_t     result0_ex2rob,
  output logic                      result0_ready_rob2alu,
  input  wire logic                 result1_valid_ex2rob,
  input  rvv_alu_pkg::ALU2ROB_t     result1_ex2rob,
  output logic                      result1_ready_rob2alu,
  output logic                      retire_valid,
  output rvv_alu_pkg::ALU2ROB_t     retire_data,
  input  wire logic                 retire_ready
);

  localparam int PTR_W = $clog2(ROB_BUF_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  rvv_alu_pkg::ALU2ROB_t mem [ROB_BUF_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] wr1_slot;
  logic [CNT_W-1:0] count;
  logic             wr0;
  logic             wr1;
  logic             retire;

  // readys from registered occupancy, a same-cycle retire is not counted
  assign result0_ready_rob2alu = (count <= CNT_W'(ROB_BUF_DEPTH - 1));
  assign result1_ready_rob2alu = (count <= CNT_W'(ROB_BUF_DEPTH - 2));

  assign wr0    = result0_valid_ex2rob && result0_ready_rob2alu;
  assign wr1    = result1_valid_ex2rob && result1_ready_rob2alu;
  assign retire = retire_valid && retire_ready;

  // lane 1 takes the slot after lane 0 when both write
  assign wr1_slot = wr0 ? wr_ptr + PTR_W'(1) : wr_ptr;

  assign retire_valid = (count != '0);
  assign retire_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(wr0) + PTR_W'(wr1);
      if (retire) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      count <= count + CNT_W'(wr0) + CNT_W'(wr1) - CNT_W'(retire);
    end
  end

  always_ff @(posedge clk) begin
    if (wr0) begin
      mem[wr_ptr] <= result0_ex2rob;
    end
    if (wr1) begin
      mem[wr1_slot] <= result1_ex2rob;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rvv_alu_rs.sv ====
// ALU reservation station
// in-order circular buffer that shows its two oldest micro-ops
// and retires 0, 1 or 2 of them per cycle
`timescale 1ns/10ps
`default_nettype none

module rvv_alu_rs #(
  parameter int RS_DEPTH = 8
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 push,
  input  rvv_alu_pkg::ALU_RS_t      uop_in,
  output logic                      rs_full,
  output rvv_alu_pkg::ALU_RS_t      alu_uop0_rs2ex,
  output rvv_alu_pkg::ALU_RS_t      alu_uop1_rs2ex,
  output logic                      fifo_empty_rs2ex,
  output logic                      fifo_1left_to_empty_rs2ex,
  input  wire logic                 pop0_ex2rs,
  input  wire logic                 pop1_ex2rs
);

  localparam int PTR_W = $clog2(RS_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  rvv_alu_pkg::ALU_RS_t mem [RS_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             push_ok;
  logic [1:0]       pop_num;

  // a push into a full station is dropped
  assign push_ok = push && !rs_full;

  // pop1 only comes with pop0, so this is 0, 1 or 2
  assign pop_num = {1'b0, pop0_ex2rs} + {1'b0, pop1_ex2rs};

  assign rs_full                   = (count == CNT_W'(RS_DEPTH));
  assign fifo_empty_rs2ex          = (count == '0);
  assign fifo_1left_to_empty_rs2ex = (count == CNT_W'(1));

  // two oldest entries, pointer wraps on its own width
  assign alu_uop0_rs2ex = mem[rd_ptr];
  assign alu_uop1_rs2ex = mem[rd_ptr + PTR_W'(1)];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      rd_ptr <= rd_ptr + PTR_W'(pop_num);
      // push and pops land in the same update
      count  <= count + CNT_W'(push_ok) - CNT_W'(pop_num);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= uop_in;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rvv_alu_top.sv ====
// vector ALU execution stage
// reservation station, dual ALU and commit buffer
`timescale 1ns/10ps
`default_nettype none

module rvv_alu_top #(
  parameter int RS_DEPTH      = 8,
  parameter int ROB_BUF_DEPTH = 4
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 push,
  input  rvv_alu_pkg::ALU_RS_t      uop_in,
  output logic                      rs_full,
  output logic                      retire_valid,
  output rvv_alu_pkg::ALU2ROB_t     retire_data,
  input  wire logic                 retire_ready
);

  rvv_alu_pkg::ALU_RS_t  alu_uop0_rs2ex;
  rvv_alu_pkg::ALU_RS_t  alu_uop1_rs2ex;
  logic                  fifo_empty_rs2ex;
  logic                  fifo_1left_to_empty_rs2ex;
  logic                  pop0_ex2rs;
  logic                  pop1_ex2rs;
  logic                  result0_valid_ex2rob;
  logic                  result1_valid_ex2rob;
  rvv_alu_pkg::ALU2ROB_t result0_ex2rob;
  rvv_alu_pkg::ALU2ROB_t result1_ex2rob;
  logic                  result0_ready_rob2alu;
  logic                  result1_ready_rob2alu;

  rvv_alu_rs #(
    .RS_DEPTH (RS_DEPTH)
  ) u_alu_rs (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .push                      (push),
    .uop_in                    (uop_in),
    .rs_full                   (rs_full),
    .alu_uop0_rs2ex            (alu_uop0_rs2ex),
    .alu_uop1_rs2ex            (alu_uop1_rs2ex),
    .fifo_empty_rs2ex          (fifo_empty_rs2ex),
    .fifo_1left_to_empty_rs2ex (fifo_1left_to_empty_rs2ex),
    .pop0_ex2rs                (pop0_ex2rs),
    .pop1_ex2rs                (pop1_ex2rs)
  );

  rvv_alu u_alu (
    .alu_uop0_rs2ex            (alu_uop0_rs2ex),
    .alu_uop1_rs2ex            (alu_uop1_rs2ex),
    .fifo_empty_rs2ex          (fifo_empty_rs2ex),
    .fifo_1left_to_empty_rs2ex (fifo_1left_to_empty_rs2ex),
    .pop0_ex2rs                (pop0_ex2rs),
    .pop1_ex2rs                (pop1_ex2rs),
    .result0_valid_ex2rob      (result0_valid_ex2rob),
    .result0_ex2rob            (result0_ex2rob),
    .result0_ready_rob2alu     (result0_ready_rob2alu),
    .result1_valid_ex2rob      (result1_valid_ex2rob),
    .result1_ex2rob            (result1_ex2rob),
    .result1_ready_rob2alu     (result1_ready_rob2alu)
  );

  rvv_alu_rob #(
    .ROB_BUF_DEPTH (ROB_BUF_DEPTH)
  ) u_alu_rob (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .result0_valid_ex2rob  (result0_valid_ex2rob),
    .result0_ex2rob        (result0_ex2rob),
    .result0_ready_rob2alu (result0_ready_rob2alu),
    .result1_valid_ex2rob  (result1_valid_ex2rob),
    .result1_ex2rob        (result1_ex2rob),
    .result1_ready_rob2alu (result1_ready_rob2alu),
    .retire_valid          (retire_valid),
    .retire_data           (retire_data),
    .retire_ready          (retire_ready)
  );

endmodule

`default_nettype wire

// ==== hw/rvv_alu_unit.sv ====
// vector ALU unit
// combinational element-wise add, sub, logic ops and unsigned min/max
// on one 32-bit slice, with SEW 8 or 16
`timescale 1ns/10ps
`default_nettype none

module rvv_alu_unit (
  input  wire logic                 alu_uop_valid,
  input  rvv_alu_pkg::ALU_RS_t      alu_uop,
  output logic                      result_valid_ex2rob,
  output rvv_alu_pkg::ALU2ROB_t     result_ex2rob
);

  // one element op, vs2 op vs1
  // bytes are zero-extended so the same code serves both widths
  function automatic logic [15:0] elem_op(
    input logic [15:0]          a,
    input logic [15:0]          b,
    input rvv_alu_pkg::alu_op_e op
  );
    logic [15:0] res;
    case (op)
      rvv_alu_pkg::OP_VADD:  res = a + b;
      rvv_alu_pkg::OP_VSUB:  res = a - b;
      rvv_alu_pkg::OP_VAND:  res = a & b;
      rvv_alu_pkg::OP_VOR:   res = a | b;
      rvv_alu_pkg::OP_VXOR:  res = a ^ b;
      rvv_alu_pkg::OP_VMINU: res = (a < b) ? a : b;
      rvv_alu_pkg::OP_VMAXU: res = (a > b) ? a : b;
      default:               res = '0;
    endcase
    return res;
  endfunction

  rvv_alu_pkg::vreg_slice_u vs1;
  rvv_alu_pkg::vreg_slice_u vs2;
  rvv_alu_pkg::vreg_slice_u vd;
  logic [15:0]              byte_res [4];

  assign vs1 = alu_uop.vs1;
  assign vs2 = alu_uop.vs2;

  // byte lanes, only the low 8 bits are kept
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      byte_res[i] = elem_op({8'h00, vs2.b[i]}, {8'h00, vs1.b[i]}, alu_uop.opcode);
    end
  end

  always_comb begin
    vd = '0;
    if (alu_uop.sew == rvv_alu_pkg::SEW8) begin
      for (int i = 0; i < 4; i++) begin
        vd.b[i] = byte_res[i][7:0];
      end
    end else begin
      // halfword view
      for (int i = 0; i < 2; i++) begin
        vd.h[i] = elem_op(vs2.h[i], vs1.h[i], alu_uop.opcode);
      end
    end
  end

  assign result_valid_ex2rob     = alu_uop_valid;
  assign result_ex2rob.rob_entry = alu_uop.rob_entry;
  assign result_ex2rob.vd_data   = vd;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the vector ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_rvv_alu -f files.f \
  && ./obj_dir/Vtb_rvv_alu > sim.log 2>&1 \
  && cat sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -q "Simulation FAILED" sim.log && { echo "failure reported in sim.log"; exit 1; } \
  || { echo "no failure reported in sim.log"; exit 0; }

// ==== verif/tb_clk_gen.sv ====
// testbench clock source
// free-running clock, 8 ns period unless overridden
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== verif/tb_rvv_alu.sv ====
// testbench for the vector ALU execution stage
// random micro-ops checked against an element-wise model, in retire order,
// under full-speed, stalled and random retire back-pressure
`timescale 1ns/10ps
`default_nettype none

module tb_rvv_alu;

  localparam int RESET_CYCLES   = 3;
  localparam int PHASE_A_CYCLES = 300;
  localparam int PHASE_B_CYCLES = 80;
  localparam int PHASE_C_CYCLES = 300;
  localparam int DRAIN_CYCLES   = 200;
  localparam int TOTAL_CYCLES   = RESET_CYCLES + PHASE_A_CYCLES + PHASE_B_CYCLES +
                                  PHASE_C_CYCLES + DRAIN_CYCLES;
  localparam int WATCHDOG_NS    = TOTAL_CYCLES * 8 * 4;

  logic                  clk;
  logic                  rst_n;
  logic                  push;
  rvv_alu_pkg::ALU_RS_t  uop_in;
  logic                  rs_full;
  logic                  retire_valid;
  rvv_alu_pkg::ALU2ROB_t retire_data;
  logic                  retire_ready;

  int                    seed = 77250;
  int                    value_errors = 0;
  int                    other_errors = 0;
  int                    push_count = 0;
  int                    retire_count = 0;
  logic [3:0]            tag = 4'd0;
  logic                  saw_full = 1'b0;
  rvv_alu_pkg::ALU2ROB_t exp_q[$];

  tb_clk_gen #(.PERIOD_NS(8.0)) u_clk_gen (.clk(clk));

  rvv_alu_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .uop_in       (uop_in),
    .rs_full      (rs_full),
    .retire_valid (retire_valid),
    .retire_data  (retire_data),
    .retire_ready (retire_ready)
  );

  // reference: each element is vs2 op vs1, wrapped to the element width
  function automatic logic [31:0] model_result(input logic [31:0] vs2_word,
                                               input logic [31:0] vs1_word,
                                               input rvv_alu_pkg::alu_op_e op,
                                               input logic sew16);
    logic [31:0] res;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic [15:0] mask;
    int          width;
    res   = '0;
    width = sew16 ? 16 : 8;
    mask  = sew16 ? 16'hffff : 16'h00ff;
    for (int i = 0; i < 32 / width; i++) begin
      a = 16'(vs2_word >> (i * width)) & mask;
      b = 16'(vs1_word >> (i * width)) & mask;
      case (op)
        rvv_alu_pkg::OP_VADD:  r = a + b;
        rvv_alu_pkg::OP_VSUB:  r = a - b;
        rvv_alu_pkg::OP_VAND:  r = a & b;
        rvv_alu_pkg::OP_VOR:   r = a | b;
        rvv_alu_pkg::OP_VXOR:  r = a ^ b;
        rvv_alu_pkg::OP_VMINU: r = (b < a) ? b : a;
        rvv_alu_pkg::OP_VMAXU: r = (b > a) ? b : a;
        default:               r = 16'h0000;
      endcase
      res = res | (32'(r & mask) << (i * width));
    end
    return res;
  endfunction

  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = $unsigned($random(seed)) % 100;
    return (r < 32'(pct));
  endfunction

  task automatic make_uop(output rvv_alu_pkg::ALU_RS_t uop);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] op_num;
    logic [31:0] sel;
    logic [31:0] rnd;
    a      = $random(seed);
    b      = $random(seed);
    sel    = $unsigned($random(seed)) % 8;
    op_num = $unsigned($random(seed)) % 7;
    rnd    = $random(seed);
    // equal operands and all-ones vs1 hit the min/max tie and sub wrap cases
    if (sel == 32'd0) begin
      b = a;
    end else if (sel == 32'd1) begin
      b = 32'hffff_ffff;
    end
    uop.rob_entry = tag;
    uop.opcode    = rvv_alu_pkg::alu_op_e'(op_num[2:0]);
    uop.sew       = rvv_alu_pkg::sew_e'(rnd[0]);
    uop.vs2       = a;
    uop.vs1       = b;
  endtask

  task automatic check_retire();
    rvv_alu_pkg::ALU2ROB_t exp_res;
    retire_count++;
    if (exp_q.size() == 0) begin
      other_errors++;
      $display("retire at time %0t with no result outstanding", $time);
    end else begin
      exp_res = exp_q.pop_front();
      if (retire_data.rob_entry !== exp_res.rob_entry) begin
        value_errors++;
        $display("Error: time %0t, retire_data.rob_entry expected %0d, got %0d",
                 $time, exp_res.rob_entry, retire_data.rob_entry);
      end
      if (retire_data.vd_data !== exp_res.vd_data) begin
        value_errors++;
        $display("Error: time %0t, retire_data.vd_data expected %h, got %h",
                 $time, exp_res.vd_data, retire_data.vd_data);
      end
    end
  endtask

  // one cycle of stimulus, all inputs change on the falling edge
  task automatic step(input int push_pct, input int ready_pct);
    rvv_alu_pkg::ALU_RS_t  uop;
    rvv_alu_pkg::ALU2ROB_t exp_res;
    @(negedge clk);
    retire_ready = chance(ready_pct);
    if (retire_valid && retire_ready) begin
      check_retire();
    end
    if (rs_full) begin
      saw_full = 1'b1;
    end
    if (!rs_full && chance(push_pct)) begin
      make_uop(uop);
      exp_res.rob_entry = uop.rob_entry;
      exp_res.vd_data   = model_result(uop.vs2, uop.vs1, uop.opcode,
                                       uop.sew == rvv_alu_pkg::SEW16);
      exp_q.push_back(exp_res);
      uop_in = uop;
      push   = 1'b1;
      tag    = tag + 4'd1;
      push_count++;
    end else begin
      push = 1'b0;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    push         = 1'b0;
    uop_in       = '0;
    retire_ready = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    if (retire_valid !== 1'b0 || rs_full !== 1'b0) begin
      other_errors++;
      $display("retire_valid or rs_full not low after reset at time %0t", $time);
    end

    // retire always ready, order checked at a heavy push rate
    for (int c = 0; c < PHASE_A_CYCLES; c++) begin
      step(90, 100);
    end

    // retire stalled, the station has to fill up
    saw_full = 1'b0;
    for (int c = 0; c < PHASE_B_CYCLES; c++) begin
      step(100, 0);
    end
    if (!saw_full) begin
      other_errors++;
      $display("rs_full never rose while retire_ready was held low");
    end

    for (int c = 0; c < PHASE_C_CYCLES; c++) begin
      step(60, 50);
    end

    // drain
    for (int c = 0; c < DRAIN_CYCLES && exp_q.size() != 0; c++) begin
      step(0, 100);
    end
    step(0, 100);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d results never retired after the drain phase", exp_q.size());
    end
    if (retire_count != push_count) begin
      other_errors++;
      $display("retired %0d results but pushed %0d micro-ops", retire_count, push_count);
    end
    // station is empty again once everything retired
    if (rs_full !== 1'b0) begin
      other_errors++;
      $display("rs_full still high after the drain phase at time %0t", $time);
    end

    $display("pushes %0d, retires %0d, value errors %0d, other errors %0d",
             push_count, retire_count, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog timeout at time %0t, retires stalled with %0d results outstanding",
             $time, exp_q.size());
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
